// ==== isa_pkg.sv ====
package isa_pkg;

    // Basic widths
    localparam int INSTR_WIDTH    = 32;
    localparam int REG_ADDR_WIDTH = 5;
    localparam int NUM_REGS       = 32;
    localparam int DATA_WIDTH     = 32;

    //////////////////////////////
    // Instruction field positions
    localparam int OPCODE_WIDTH    = 7;
    localparam int OPCODE_LSB      = 25;
    localparam int RD_LSB          = 20;
    localparam int RA_LSB          = 15;
    localparam int RB_LSB          = 10;
    localparam int IMM_LO_WIDTH    = 15;
    // Low offset of branch and jump in bits 9..0
    localparam int OFFSET_LO_WIDTH = 10;

    typedef enum logic [OPCODE_WIDTH-1:0] {
        OP_ADD   = 7'h00,
        OP_SUB   = 7'h01,
        OP_MUL   = 7'h02,
        OP_ADDI  = 7'h03,
        OP_LOAD  = 7'h10,
        OP_STORE = 7'h11,
        OP_BEQ   = 7'h30,
        OP_JUMP  = 7'h31,
        OP_NOP   = 7'h7F
    } opcode_t;

    // Decoded instruction class
    typedef enum logic [3:0] {
        R_TYPE,
        ADDI,
        LOAD,
        STORE,
        BRANCH,
        JUMP,
        MUL,
        NOP,
        ILLEGAL
    } instr_class_t;

endpackage

// ==== dispatch_pkg.sv ====
package dispatch_pkg;

    localparam int ROB_ID_WIDTH = 4;
    localparam int PC_WIDTH     = 32;

    typedef logic [ROB_ID_WIDTH-1:0] rob_id_t;

    // Source operands with their pending producers
    typedef struct packed {
        logic [isa_pkg::DATA_WIDTH-1:0] ra_data;
        logic [isa_pkg::DATA_WIDTH-1:0] rb_data;
        rob_id_t                        ticket_src1;
        logic                           blocks_src1;
        rob_id_t                        ticket_src2;
        logic                           blocks_src2;
    } operands_t;

    //////////////////////////////
    // Requests to the execution units
    typedef struct packed {
        isa_pkg::opcode_t                   opcode;
        logic [isa_pkg::REG_ADDR_WIDTH-1:0] rd_addr;
        operands_t                          ops;
        logic [isa_pkg::DATA_WIDTH-1:0]     offset;
        rob_id_t                            rob_id;
        logic [PC_WIDTH-1:0]                pc;
        logic                               xcpt_illegal;
    } alu_req_t;

    typedef struct packed {
        logic [isa_pkg::REG_ADDR_WIDTH-1:0] rd_addr;
        operands_t                          ops;
        rob_id_t                            rob_id;
        logic [PC_WIDTH-1:0]                pc;
    } mul_req_t;

endpackage

// ==== instr_decoder.sv ====
`timescale 1ns/1ps

module instr_decoder
(
    input  logic [isa_pkg::INSTR_WIDTH-1:0]    instr,

    output isa_pkg::opcode_t                   opcode,
    output isa_pkg::instr_class_t              instr_class,
    output logic [isa_pkg::REG_ADDR_WIDTH-1:0] rd_addr,
    output logic [isa_pkg::REG_ADDR_WIDTH-1:0] src1_addr,
    output logic [isa_pkg::REG_ADDR_WIDTH-1:0] src2_addr,
    output logic                               uses_src1,
    output logic                               uses_src2,
    output logic                               writes_rd,
    output logic [isa_pkg::DATA_WIDTH-1:0]     imm
);

typedef logic [isa_pkg::DATA_WIDTH-1:0] word_t;

logic [isa_pkg::REG_ADDR_WIDTH-1:0]  ra_field;
logic [isa_pkg::REG_ADDR_WIDTH-1:0]  rb_field;
logic [isa_pkg::IMM_LO_WIDTH-1:0]    imm_lo;
logic [isa_pkg::OFFSET_LO_WIDTH-1:0] offset_lo;
logic                                is_store;

//////////////////////////////
// Field extraction
assign opcode    = isa_pkg::opcode_t'(instr[isa_pkg::OPCODE_LSB +: isa_pkg::OPCODE_WIDTH]);
assign rd_addr   = instr[isa_pkg::RD_LSB +: isa_pkg::REG_ADDR_WIDTH];
assign ra_field  = instr[isa_pkg::RA_LSB +: isa_pkg::REG_ADDR_WIDTH];
assign rb_field  = instr[isa_pkg::RB_LSB +: isa_pkg::REG_ADDR_WIDTH];
assign imm_lo    = instr[isa_pkg::IMM_LO_WIDTH-1:0];
assign offset_lo = instr[isa_pkg::OFFSET_LO_WIDTH-1:0];

always_comb
begin
    unique case (opcode)
        isa_pkg::OP_ADD,
        isa_pkg::OP_SUB:   instr_class = isa_pkg::R_TYPE;
        isa_pkg::OP_MUL:   instr_class = isa_pkg::MUL;
        isa_pkg::OP_ADDI:  instr_class = isa_pkg::ADDI;
        isa_pkg::OP_LOAD:  instr_class = isa_pkg::LOAD;
        isa_pkg::OP_STORE: instr_class = isa_pkg::STORE;
        isa_pkg::OP_BEQ:   instr_class = isa_pkg::BRANCH;
        isa_pkg::OP_JUMP:  instr_class = isa_pkg::JUMP;
        isa_pkg::OP_NOP:   instr_class = isa_pkg::NOP;
        default:           instr_class = isa_pkg::ILLEGAL;
    endcase
end

// Store reads the value to write through the rd field
assign is_store  = (instr_class == isa_pkg::STORE);
assign src1_addr = ra_field;
assign src2_addr = is_store ? rd_addr : rb_field;

assign uses_src1 = instr_class inside {isa_pkg::R_TYPE, isa_pkg::MUL, isa_pkg::ADDI,
                                       isa_pkg::LOAD, isa_pkg::STORE, isa_pkg::BRANCH};
assign uses_src2 = instr_class inside {isa_pkg::R_TYPE, isa_pkg::MUL, isa_pkg::STORE,
                                       isa_pkg::BRANCH};
assign writes_rd = instr_class inside {isa_pkg::R_TYPE, isa_pkg::ADDI, isa_pkg::MUL,
                                       isa_pkg::LOAD};

//////////////////////////////
// Immediates are always zero-extended
always_comb
begin
    case (instr_class)
        isa_pkg::BRANCH: imm = word_t'({rd_addr, offset_lo});
        isa_pkg::JUMP:   imm = word_t'({rd_addr, ra_field, offset_lo});
        default:         imm = word_t'(imm_lo);
    endcase
end

endmodule

// ==== reg_file.sv ====
`timescale 1ns/1ps

module reg_file
(
    input  logic                               clock,
    input  logic                               rst,

    input  logic [isa_pkg::REG_ADDR_WIDTH-1:0] rd_addr_a,
    input  logic [isa_pkg::REG_ADDR_WIDTH-1:0] rd_addr_b,
    output logic [isa_pkg::DATA_WIDTH-1:0]     rd_data_a,
    output logic [isa_pkg::DATA_WIDTH-1:0]     rd_data_b,

    input  logic                               wb_valid,
    input  logic [isa_pkg::REG_ADDR_WIDTH-1:0] wb_addr,
    input  logic [isa_pkg::DATA_WIDTH-1:0]     wb_data
);

logic [isa_pkg::DATA_WIDTH-1:0] regs [isa_pkg::NUM_REGS];

always_ff @(posedge clock)
begin
    if (rst)
    begin
        for (int i = 0; i < isa_pkg::NUM_REGS; i++)
            regs[i] <= '0;
    end
    else if (wb_valid)
    begin
        regs[wb_addr] <= wb_data;
    end
end

// Same-cycle bypass from write-back
assign rd_data_a = (wb_valid && (wb_addr == rd_addr_a)) ? wb_data : regs[rd_addr_a];
assign rd_data_b = (wb_valid && (wb_addr == rd_addr_b)) ? wb_data : regs[rd_addr_b];

endmodule

// ==== scoreboard.sv ====
`timescale 1ns/1ps

module scoreboard
(
    input  logic                               clock,
    input  logic                               rst,

    // Instruction being issued
    input  logic                               issue,
    input  logic [isa_pkg::REG_ADDR_WIDTH-1:0] dest_addr,
    input  logic                               writes_rd,
    input  logic [isa_pkg::REG_ADDR_WIDTH-1:0] src1_addr,
    input  logic [isa_pkg::REG_ADDR_WIDTH-1:0] src2_addr,
    input  logic                               uses_src1,
    input  logic                               uses_src2,

    // Write-back
    input  logic                               wb_valid,
    input  logic [isa_pkg::REG_ADDR_WIDTH-1:0] wb_addr,
    input  dispatch_pkg::rob_id_t              wb_rob_id,

    output dispatch_pkg::rob_id_t              rob_id,
    output dispatch_pkg::rob_id_t              ticket_src1,
    output logic                               blocks_src1,
    output dispatch_pkg::rob_id_t              ticket_src2,
    output logic                               blocks_src2
);

logic [isa_pkg::NUM_REGS-1:0] blocked;
dispatch_pkg::rob_id_t        tickets [isa_pkg::NUM_REGS];
dispatch_pkg::rob_id_t        tail;
logic                         release_wb;

// Only the producer holding the ticket may clear the block
assign release_wb = wb_valid && blocked[wb_addr] && (tickets[wb_addr] == wb_rob_id);

always_ff @(posedge clock)
begin
    if (rst)
    begin
        tail    <= '0;
        blocked <= '0;
        for (int i = 0; i < isa_pkg::NUM_REGS; i++)
            tickets[i] <= '0;
    end
    else
    begin
        if (release_wb)
            blocked[wb_addr] <= 1'b0;
        // Mark comes last so it wins over a release of the same register
        if (issue)
        begin
            tail <= tail + 1'b1;
            if (writes_rd)
            begin
                blocked[dest_addr] <= 1'b1;
                tickets[dest_addr] <= tail;
            end
        end
    end
end

//////////////////////////////
// Source lookup
assign rob_id      = tail;
assign ticket_src1 = uses_src1 ? tickets[src1_addr] : '0;
assign ticket_src2 = uses_src2 ? tickets[src2_addr] : '0;
assign blocks_src1 = uses_src1 && blocked[src1_addr] && !(release_wb && (wb_addr == src1_addr));
assign blocks_src2 = uses_src2 && blocked[src2_addr] && !(release_wb && (wb_addr == src2_addr));

// An issue must come with a decoded instruction behind it
assert property (@(posedge clock) disable iff (rst)
    issue |-> !$isunknown({writes_rd, dest_addr}))
    else $error("scoreboard: issue without a valid decoded instruction");

endmodule

// ==== issue_ctrl.sv ====
`timescale 1ns/1ps

module issue_ctrl
#(
    parameter int ALU_CREDITS = 2,
    parameter int MUL_CREDITS = 2
)
(
    input  logic                                 clock,
    input  logic                                 rst,

    input  logic                                 fetch_valid,
    input  logic [dispatch_pkg::PC_WIDTH-1:0]    fetch_pc,
    output logic                                 fetch_ready,

    // Decoded instruction and operands
    input  isa_pkg::opcode_t                     opcode,
    input  isa_pkg::instr_class_t                instr_class,
    input  logic [isa_pkg::REG_ADDR_WIDTH-1:0]   rd_addr,
    input  logic [isa_pkg::DATA_WIDTH-1:0]       imm,
    input  logic [isa_pkg::DATA_WIDTH-1:0]       ra_data,
    input  logic [isa_pkg::DATA_WIDTH-1:0]       rb_data,
    input  dispatch_pkg::rob_id_t                ticket_src1,
    input  logic                                 blocks_src1,
    input  dispatch_pkg::rob_id_t                ticket_src2,
    input  logic                                 blocks_src2,
    input  dispatch_pkg::rob_id_t                rob_id,

    input  logic                                 alu_credit_return,
    input  logic                                 mul_credit_return,

    output logic                                 issue,
    output logic                                 alu_load,
    output dispatch_pkg::alu_req_t               alu_payload,
    output logic                                 mul_load,
    output dispatch_pkg::mul_req_t               mul_payload
);

localparam int MAX_CREDITS = (ALU_CREDITS > MUL_CREDITS) ? ALU_CREDITS : MUL_CREDITS;
localparam int CNT_WIDTH   = $clog2(MAX_CREDITS + 1);

typedef logic [CNT_WIDTH-1:0] cnt_t;

cnt_t                    alu_cnt;
cnt_t                    mul_cnt;
logic                    to_mul;
dispatch_pkg::operands_t ops;

// Net change of one counter for a cycle
function automatic cnt_t credit_next(cnt_t cnt, logic take, logic give);
    case ({take, give})
        2'b10:   credit_next = cnt - 1'b1;
        2'b01:   credit_next = cnt + 1'b1;
        default: credit_next = cnt;
    endcase
endfunction

//////////////////////////////
// Target and flow control
assign to_mul      = (instr_class == isa_pkg::MUL);
assign fetch_ready = to_mul ? (mul_cnt != '0) : (alu_cnt != '0);
assign issue       = fetch_valid && fetch_ready;
assign alu_load    = issue && !to_mul;
assign mul_load    = issue && to_mul;

always_ff @(posedge clock)
begin
    if (rst)
    begin
        alu_cnt <= cnt_t'(ALU_CREDITS);
        mul_cnt <= cnt_t'(MUL_CREDITS);
    end
    else
    begin
        alu_cnt <= credit_next(alu_cnt, alu_load, alu_credit_return);
        mul_cnt <= credit_next(mul_cnt, mul_load, mul_credit_return);
    end
end

//////////////////////////////
// Request payloads
always_comb
begin
    ops.ra_data     = ra_data;
    ops.rb_data     = rb_data;
    ops.ticket_src1 = ticket_src1;
    ops.blocks_src1 = blocks_src1;
    ops.ticket_src2 = ticket_src2;
    ops.blocks_src2 = blocks_src2;

    alu_payload.opcode       = opcode;
    alu_payload.rd_addr      = rd_addr;
    alu_payload.ops          = ops;
    alu_payload.offset       = imm;
    alu_payload.rob_id       = rob_id;
    alu_payload.pc           = fetch_pc;
    alu_payload.xcpt_illegal = (instr_class == isa_pkg::ILLEGAL);

    mul_payload.rd_addr = rd_addr;
    mul_payload.ops     = ops;
    mul_payload.rob_id  = rob_id;
    mul_payload.pc      = fetch_pc;
end

// Units must never hand back more credits than were taken
assert property (@(posedge clock) disable iff (rst)
    (alu_credit_return && !alu_load) |-> (alu_cnt < ALU_CREDITS))
    else $error("issue_ctrl: ALU credit overflow");
assert property (@(posedge clock) disable iff (rst)
    (mul_credit_return && !mul_load) |-> (mul_cnt < MUL_CREDITS))
    else $error("issue_ctrl: MUL credit overflow");

endmodule

// ==== dispatch_reg.sv ====
`timescale 1ns/1ps

module dispatch_reg
#(
    parameter type payload_t = logic
)
(
    input  logic     clock,
    input  logic     rst,

    input  logic     load,
    input  payload_t payload_in,

    output logic     req_valid,
    output payload_t req
);

// Valid lasts exactly one cycle per load
always_ff @(posedge clock)
begin
    if (rst)
        req_valid <= 1'b0;
    else
        req_valid <= load;
end

always_ff @(posedge clock)
begin
    if (load)
        req <= payload_in;
end

endmodule

// ==== decode_stage_top.sv ====
`timescale 1ns/1ps

module decode_stage_top
#(
    parameter int ALU_CREDITS = 2,
    parameter int MUL_CREDITS = 2
)
(
    input  logic                               clock,
    input  logic                               rst,

    // Fetch
    input  logic                               fetch_valid,
    input  logic [isa_pkg::INSTR_WIDTH-1:0]    fetch_instr,
    input  logic [dispatch_pkg::PC_WIDTH-1:0]  fetch_pc,
    output logic                               fetch_ready,

    // Write-back
    input  logic                               wb_valid,
    input  logic [isa_pkg::REG_ADDR_WIDTH-1:0] wb_addr,
    input  logic [isa_pkg::DATA_WIDTH-1:0]     wb_data,
    input  dispatch_pkg::rob_id_t              wb_rob_id,

    input  logic                               alu_credit_return,
    input  logic                               mul_credit_return,

    output logic                               alu_req_valid,
    output dispatch_pkg::alu_req_t             alu_req,
    output logic                               mul_req_valid,
    output dispatch_pkg::mul_req_t             mul_req
);

isa_pkg::opcode_t                   opcode;
isa_pkg::instr_class_t              instr_class;
logic [isa_pkg::REG_ADDR_WIDTH-1:0] rd_addr;
logic [isa_pkg::REG_ADDR_WIDTH-1:0] src1_addr;
logic [isa_pkg::REG_ADDR_WIDTH-1:0] src2_addr;
logic                               uses_src1;
logic                               uses_src2;
logic                               writes_rd;
logic [isa_pkg::DATA_WIDTH-1:0]     imm;
logic [isa_pkg::DATA_WIDTH-1:0]     ra_data;
logic [isa_pkg::DATA_WIDTH-1:0]     rb_data;
dispatch_pkg::rob_id_t              rob_id;
dispatch_pkg::rob_id_t              ticket_src1;
dispatch_pkg::rob_id_t              ticket_src2;
logic                               blocks_src1;
logic                               blocks_src2;
logic                               issue;
logic                               alu_load;
logic                               mul_load;
dispatch_pkg::alu_req_t             alu_payload;
dispatch_pkg::mul_req_t             mul_payload;

//////////////////////////////
// Decode
instr_decoder decoder0
(
    .instr       ( fetch_instr ),
    .opcode      ( opcode      ),
    .instr_class ( instr_class ),
    .rd_addr     ( rd_addr     ),
    .src1_addr   ( src1_addr   ),
    .src2_addr   ( src2_addr   ),
    .uses_src1   ( uses_src1   ),
    .uses_src2   ( uses_src2   ),
    .writes_rd   ( writes_rd   ),
    .imm         ( imm         )
);

//////////////////////////////
// Result side
reg_file regs0
(
    .clock     ( clock     ),
    .rst       ( rst       ),
    .rd_addr_a ( src1_addr ),
    .rd_addr_b ( src2_addr ),
    .rd_data_a ( ra_data   ),
    .rd_data_b ( rb_data   ),
    .wb_valid  ( wb_valid  ),
    .wb_addr   ( wb_addr   ),
    .wb_data   ( wb_data   )
);

scoreboard sb0
(
    .clock       ( clock       ),
    .rst         ( rst         ),
    .issue       ( issue       ),
    .dest_addr   ( rd_addr     ),
    .writes_rd   ( writes_rd   ),
    .src1_addr   ( src1_addr   ),
    .src2_addr   ( src2_addr   ),
    .uses_src1   ( uses_src1   ),
    .uses_src2   ( uses_src2   ),
    .wb_valid    ( wb_valid    ),
    .wb_addr     ( wb_addr     ),
    .wb_rob_id   ( wb_rob_id   ),
    .rob_id      ( rob_id      ),
    .ticket_src1 ( ticket_src1 ),
    .blocks_src1 ( blocks_src1 ),
    .ticket_src2 ( ticket_src2 ),
    .blocks_src2 ( blocks_src2 )
);

//////////////////////////////
// Issue towards execute
issue_ctrl
#(
    .ALU_CREDITS ( ALU_CREDITS ),
    .MUL_CREDITS ( MUL_CREDITS )
)
issue0
(
    .clock             ( clock             ),
    .rst               ( rst               ),
    .fetch_valid       ( fetch_valid       ),
    .fetch_pc          ( fetch_pc          ),
    .fetch_ready       ( fetch_ready       ),
    .opcode            ( opcode            ),
    .instr_class       ( instr_class       ),
    .rd_addr           ( rd_addr           ),
    .imm               ( imm               ),
    .ra_data           ( ra_data           ),
    .rb_data           ( rb_data           ),
    .ticket_src1       ( ticket_src1       ),
    .blocks_src1       ( blocks_src1       ),
    .ticket_src2       ( ticket_src2       ),
    .blocks_src2       ( blocks_src2       ),
    .rob_id            ( rob_id            ),
    .alu_credit_return ( alu_credit_return ),
    .mul_credit_return ( mul_credit_return ),
    .issue             ( issue             ),
    .alu_load          ( alu_load          ),
    .alu_payload       ( alu_payload       ),
    .mul_load          ( mul_load          ),
    .mul_payload       ( mul_payload       )
);

dispatch_reg #(.payload_t(dispatch_pkg::alu_req_t)) alu_dispatch0
(
    .clock      ( clock         ),
    .rst        ( rst           ),
    .load       ( alu_load      ),
    .payload_in ( alu_payload   ),
    .req_valid  ( alu_req_valid ),
    .req        ( alu_req       )
);

dispatch_reg #(.payload_t(dispatch_pkg::mul_req_t)) mul_dispatch0
(
    .clock      ( clock         ),
    .rst        ( rst           ),
    .load       ( mul_load      ),
    .payload_in ( mul_payload   ),
    .req_valid  ( mul_req_valid ),
    .req        ( mul_req       )
);

endmodule

// ==== decode_stage_tb.sv ====
`timescale 1ns/1ps

module decode_stage_tb;

localparam int  ALU_CREDITS = 2;
localparam int  MUL_CREDITS = 2;
localparam int  NUM_OPS     = 100;
localparam real CLK_PERIOD  = 20.0;
localparam real TIMEOUT_NS  = 200.0 * NUM_OPS * CLK_PERIOD;

typedef logic [isa_pkg::DATA_WIDTH-1:0]     word_t;
typedef logic [isa_pkg::REG_ADDR_WIDTH-1:0] addr_t;

logic                              clock = 1'b0;
logic                              rst;
logic                              fetch_valid;
logic [isa_pkg::INSTR_WIDTH-1:0]   fetch_instr;
logic [dispatch_pkg::PC_WIDTH-1:0] fetch_pc;
logic                              fetch_ready;
logic                              wb_valid;
addr_t                             wb_addr;
word_t                             wb_data;
dispatch_pkg::rob_id_t             wb_rob_id;
logic                              alu_credit_return;
logic                              mul_credit_return;
logic                              alu_req_valid;
dispatch_pkg::alu_req_t            alu_req;
logic                              mul_req_valid;
dispatch_pkg::mul_req_t            mul_req;

// Reference model state
word_t                        m_regs [isa_pkg::NUM_REGS];
logic [isa_pkg::NUM_REGS-1:0] m_blocked;
dispatch_pkg::rob_id_t        m_tickets [isa_pkg::NUM_REGS];
dispatch_pkg::rob_id_t        m_tail;
int                           m_alu_cred = ALU_CREDITS;
int                           m_mul_cred = MUL_CREDITS;
int                           alu_in_flight;
int                           mul_in_flight;
logic                         model_ready;
logic                         last_accept;
logic                         exp_alu_valid;
logic                         exp_mul_valid;
dispatch_pkg::alu_req_t       exp_alu;
dispatch_pkg::mul_req_t       exp_mul;

// Scratch of the model for one edge
isa_pkg::instr_class_t   cls;
addr_t                   src1;
addr_t                   src2;
logic                    use1;
logic                    use2;
logic                    accept;
logic                    release_hit;
dispatch_pkg::operands_t ops;
dispatch_pkg::alu_req_t  alu_n;
dispatch_pkg::mul_req_t  mul_n;

string test_name = "reset";
int    errors = 0;
int    return_pct = 100;

decode_stage_top
#(
    .ALU_CREDITS ( ALU_CREDITS ),
    .MUL_CREDITS ( MUL_CREDITS )
)
dut0
(
    .clock             ( clock             ),
    .rst               ( rst               ),
    .fetch_valid       ( fetch_valid       ),
    .fetch_instr       ( fetch_instr       ),
    .fetch_pc          ( fetch_pc          ),
    .fetch_ready       ( fetch_ready       ),
    .wb_valid          ( wb_valid          ),
    .wb_addr           ( wb_addr           ),
    .wb_data           ( wb_data           ),
    .wb_rob_id         ( wb_rob_id         ),
    .alu_credit_return ( alu_credit_return ),
    .mul_credit_return ( mul_credit_return ),
    .alu_req_valid     ( alu_req_valid     ),
    .alu_req           ( alu_req           ),
    .mul_req_valid     ( mul_req_valid     ),
    .mul_req           ( mul_req           )
);

always #(CLK_PERIOD / 2) clock = ~clock;

//////////////////////////////
// Instruction set rules
function automatic isa_pkg::instr_class_t class_of(logic [6:0] op);
    case (op)
        isa_pkg::OP_ADD,
        isa_pkg::OP_SUB:   class_of = isa_pkg::R_TYPE;
        isa_pkg::OP_MUL:   class_of = isa_pkg::MUL;
        isa_pkg::OP_ADDI:  class_of = isa_pkg::ADDI;
        isa_pkg::OP_LOAD:  class_of = isa_pkg::LOAD;
        isa_pkg::OP_STORE: class_of = isa_pkg::STORE;
        isa_pkg::OP_BEQ:   class_of = isa_pkg::BRANCH;
        isa_pkg::OP_JUMP:  class_of = isa_pkg::JUMP;
        isa_pkg::OP_NOP:   class_of = isa_pkg::NOP;
        default:           class_of = isa_pkg::ILLEGAL;
    endcase
endfunction

function automatic logic reads_src1(isa_pkg::instr_class_t c);
    reads_src1 = c inside {isa_pkg::R_TYPE, isa_pkg::MUL, isa_pkg::ADDI,
                           isa_pkg::LOAD, isa_pkg::STORE, isa_pkg::BRANCH};
endfunction

function automatic logic reads_src2(isa_pkg::instr_class_t c);
    reads_src2 = c inside {isa_pkg::R_TYPE, isa_pkg::MUL, isa_pkg::STORE, isa_pkg::BRANCH};
endfunction

function automatic logic writes_dest(isa_pkg::instr_class_t c);
    writes_dest = c inside {isa_pkg::R_TYPE, isa_pkg::ADDI, isa_pkg::MUL, isa_pkg::LOAD};
endfunction

// Branch takes rd then low10 and jump takes rd, ra then low10
function automatic word_t imm_of(isa_pkg::instr_class_t c, logic [31:0] instr);
    case (c)
        isa_pkg::BRANCH: imm_of = {17'b0, instr[24:20], instr[9:0]};
        isa_pkg::JUMP:   imm_of = {12'b0, instr[24:20], instr[19:15], instr[9:0]};
        default:         imm_of = {17'b0, instr[14:0]};
    endcase
endfunction

function automatic logic [31:0] enc(logic [6:0] op, addr_t rd, addr_t ra, addr_t rb,
                                    logic [9:0] lo10);
    enc = {op, rd, ra, rb, lo10};
endfunction

// Register read as the model sees it with write-back bypass
function automatic word_t read_model(addr_t a);
    read_model = (wb_valid && wb_addr == a) ? wb_data : m_regs[a];
endfunction

assign model_ready = (class_of(fetch_instr[31:25]) == isa_pkg::MUL) ? (m_mul_cred != 0)
                                                                     : (m_alu_cred != 0);

//////////////////////////////
// Reference model
always @(posedge clock)
begin
    if (rst)
    begin
        for (int i = 0; i < isa_pkg::NUM_REGS; i++)
        begin
            m_regs[i]    = '0;
            m_tickets[i] = '0;
        end
        m_blocked     = '0;
        m_tail        = '0;
        m_alu_cred    = ALU_CREDITS;
        m_mul_cred    = MUL_CREDITS;
        alu_in_flight = 0;
        mul_in_flight = 0;
        last_accept   <= 1'b0;
        exp_alu_valid <= 1'b0;
        exp_mul_valid <= 1'b0;
    end
    else
    begin
        cls         = class_of(fetch_instr[31:25]);
        accept      = fetch_valid && model_ready;
        use1        = reads_src1(cls);
        use2        = reads_src2(cls);
        src1        = fetch_instr[19:15];
        src2        = (cls == isa_pkg::STORE) ? fetch_instr[24:20] : fetch_instr[14:10];
        release_hit = wb_valid && m_blocked[wb_addr] && (m_tickets[wb_addr] == wb_rob_id);

        ops.ra_data     = read_model(src1);
        ops.rb_data     = read_model(src2);
        ops.ticket_src1 = use1 ? m_tickets[src1] : '0;
        ops.ticket_src2 = use2 ? m_tickets[src2] : '0;
        ops.blocks_src1 = use1 && m_blocked[src1] && !(release_hit && wb_addr == src1);
        ops.blocks_src2 = use2 && m_blocked[src2] && !(release_hit && wb_addr == src2);

        alu_n.opcode       = isa_pkg::opcode_t'(fetch_instr[31:25]);
        alu_n.rd_addr      = fetch_instr[24:20];
        alu_n.ops          = ops;
        alu_n.offset       = imm_of(cls, fetch_instr);
        alu_n.rob_id       = m_tail;
        alu_n.pc           = fetch_pc;
        alu_n.xcpt_illegal = (cls == isa_pkg::ILLEGAL);
        mul_n.rd_addr      = fetch_instr[24:20];
        mul_n.ops          = ops;
        mul_n.rob_id       = m_tail;
        mul_n.pc           = fetch_pc;

        last_accept   <= accept;
        exp_alu_valid <= accept && (cls != isa_pkg::MUL);
        exp_mul_valid <= accept && (cls == isa_pkg::MUL);
        exp_alu       <= alu_n;
        exp_mul       <= mul_n;

        if (wb_valid)
            m_regs[wb_addr] = wb_data;
        if (release_hit)
            m_blocked[wb_addr] = 1'b0;
        // A new mark overrides a release of the same register
        if (accept)
        begin
            if (writes_dest(cls))
            begin
                m_blocked[fetch_instr[24:20]] = 1'b1;
                m_tickets[fetch_instr[24:20]] = m_tail;
            end
            m_tail = m_tail + 1'b1;
        end

        m_alu_cred = m_alu_cred - int'(accept && cls != isa_pkg::MUL) + int'(alu_credit_return);
        m_mul_cred = m_mul_cred - int'(accept && cls == isa_pkg::MUL) + int'(mul_credit_return);
        alu_in_flight = alu_in_flight + int'(alu_req_valid) - int'(alu_credit_return);
        mul_in_flight = mul_in_flight + int'(mul_req_valid) - int'(mul_credit_return);
    end
end

task automatic report_mismatch(string what, logic [255:0] expected, logic [255:0] actual);
    errors++;
    $display("error %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
endtask

task automatic report_failure(string msg);
    errors++;
    $display("%s: %s", test_name, msg);
endtask

//////////////////////////////
// Checks against the model
assert property (@(posedge clock) disable iff (rst) fetch_ready == model_ready)
    else report_mismatch("fetch_ready", $sampled(model_ready), $sampled(fetch_ready));
assert property (@(posedge clock) disable iff (rst) alu_req_valid == exp_alu_valid)
    else report_mismatch("alu_req_valid", $sampled(exp_alu_valid), $sampled(alu_req_valid));
assert property (@(posedge clock) disable iff (rst) mul_req_valid == exp_mul_valid)
    else report_mismatch("mul_req_valid", $sampled(exp_mul_valid), $sampled(mul_req_valid));
assert property (@(posedge clock) disable iff (rst) alu_req_valid |-> alu_req == exp_alu)
    else report_mismatch("alu_req", $sampled(exp_alu), $sampled(alu_req));
assert property (@(posedge clock) disable iff (rst) mul_req_valid |-> mul_req == exp_mul)
    else report_mismatch("mul_req", $sampled(exp_mul), $sampled(mul_req));
assert property (@(posedge clock) disable iff (rst) alu_in_flight <= ALU_CREDITS)
    else report_failure("more ALU requests in flight than ALU credits");
assert property (@(posedge clock) disable iff (rst) mul_in_flight <= MUL_CREDITS)
    else report_failure("more MUL requests in flight than MUL credits");

//////////////////////////////
// Stimulus
task automatic step();
    @(posedge clock);
    #2;
    wb_valid          = 1'b0;
    alu_credit_return = (m_alu_cred < ALU_CREDITS) && (($urandom % 100) < return_pct);
    mul_credit_return = (m_mul_cred < MUL_CREDITS) && (($urandom % 100) < return_pct);
endtask

task automatic present(string name, logic [31:0] instr);
    test_name   = name;
    fetch_instr = instr;
    fetch_valid = 1'b1;
endtask

task automatic wait_accept();
    do
        step();
    while (!last_accept);
    fetch_valid = 1'b0;
    fetch_pc    = fetch_pc + 4;
endtask

task automatic send(string name, logic [31:0] instr);
    present(name, instr);
    wait_accept();
endtask

// Lands at the next edge with the ticket the model holds for addr
task automatic writeback(addr_t addr, word_t data);
    wb_addr   = addr;
    wb_data   = data;
    wb_rob_id = m_tickets[addr];
    wb_valid  = 1'b1;
endtask

initial
begin
    isa_pkg::opcode_t op_table [9];
    int               pick;
    addr_t            r;
    logic [6:0]       op;

    op_table = '{isa_pkg::OP_ADD, isa_pkg::OP_SUB, isa_pkg::OP_MUL,
                 isa_pkg::OP_ADDI, isa_pkg::OP_LOAD, isa_pkg::OP_STORE,
                 isa_pkg::OP_BEQ, isa_pkg::OP_JUMP, isa_pkg::OP_NOP};

    void'($urandom(48));
    rst               = 1'b1;
    fetch_valid       = 1'b0;
    fetch_instr       = '0;
    fetch_pc          = 32'h0000_1000;
    wb_valid          = 1'b0;
    wb_addr           = '0;
    wb_data           = '0;
    wb_rob_id         = '0;
    alu_credit_return = 1'b0;
    mul_credit_return = 1'b0;
    repeat (8) step();
    rst = 1'b0;
    step();

    // Routing to the units
    send("alu_add", enc(isa_pkg::OP_ADD, 5'd1, 5'd2, 5'd3, 10'h0));
    send("mul", enc(isa_pkg::OP_MUL, 5'd4, 5'd1, 5'd2, 10'h0));
    send("illegal", enc(7'h55, 5'd5, 5'd6, 5'd7, 10'h012));
    send("nop", enc(isa_pkg::OP_NOP, 5'd0, 5'd0, 5'd0, 10'h0));

    // Immediates
    send("addi", enc(isa_pkg::OP_ADDI, 5'd8, 5'd1, 5'h1b, 10'h2a5));
    send("load", enc(isa_pkg::OP_LOAD, 5'd9, 5'd8, 5'h07, 10'h3ff));
    send("store", enc(isa_pkg::OP_STORE, 5'd9, 5'd8, 5'h12, 10'h001));
    send("branch", enc(isa_pkg::OP_BEQ, 5'h15, 5'd3, 5'd4, 10'h155));
    send("jump", enc(isa_pkg::OP_JUMP, 5'h1f, 5'h0a, 5'h00, 10'h2aa));

    // Dependencies and write-back release
    writeback(5'd2, 32'h0000_0222);
    step();
    send("dep_producer", enc(isa_pkg::OP_ADD, 5'd10, 5'd2, 5'd2, 10'h0));
    send("dep_blocked", enc(isa_pkg::OP_SUB, 5'd11, 5'd10, 5'd2, 10'h0));
    writeback(5'd10, 32'h1234_5678);
    step();
    send("dep_released", enc(isa_pkg::OP_ADD, 5'd12, 5'd10, 5'd10, 10'h0));
    send("dep_mul", enc(isa_pkg::OP_MUL, 5'd13, 5'd10, 5'd2, 10'h0));
    writeback(5'd13, 32'hcafe_0013);
    send("dep_same_cycle", enc(isa_pkg::OP_STORE, 5'd13, 5'd13, 5'd0, 10'h004));
    writeback(5'd12, 32'h0bad_0012);
    send("mark_over_release", enc(isa_pkg::OP_ADDI, 5'd12, 5'd12, 5'd0, 10'h001));
    send("mark_check", enc(isa_pkg::OP_ADD, 5'd14, 5'd12, 5'd0, 10'h0));

    // Back-pressure with no credit returns
    return_pct = 0;
    step();
    step();
    while (m_alu_cred > 0)
        send("credit_fill_alu", enc(isa_pkg::OP_ADD, 5'd15, 5'd0, 5'd0, 10'h0));
    present("credit_stall_alu", enc(isa_pkg::OP_ADD, 5'd16, 5'd0, 5'd0, 10'h0));
    repeat (4) step();
    return_pct = 100;
    wait_accept();
    return_pct = 0;
    step();
    step();
    while (m_mul_cred > 0)
        send("credit_fill_mul", enc(isa_pkg::OP_MUL, 5'd17, 5'd1, 5'd2, 10'h0));
    present("credit_stall_mul", enc(isa_pkg::OP_MUL, 5'd18, 5'd1, 5'd2, 10'h0));
    repeat (4) step();
    return_pct = 100;
    wait_accept();

    // Random mix with random credit returns
    return_pct = 50;
    for (int n = 0; n < 40; n++)
    begin
        pick = $urandom % 10;
        op   = (pick == 9) ? 7'($urandom) : op_table[pick];
        r    = addr_t'($urandom % 32);
        if ((($urandom % 3) == 0) && m_blocked[r])
            writeback(r, $urandom);
        send("random", enc(op, addr_t'($urandom), addr_t'($urandom), addr_t'($urandom),
                           10'($urandom)));
    end

    return_pct = 100;
    repeat (6) step();
    $display("checks done, errors: %0d", errors);
    if (errors == 0)
        $display("TEST PASSED");
    else
        $display("TEST FAILED");
    $finish;
end

// Watchdog
initial
begin
    #(TIMEOUT_NS);
    $display("watchdog expired in %s, the run did not finish, errors: %0d", test_name, errors);
    $display("TEST FAILED");
    $finish;
end

endmodule

// ==== filelist.f ====
isa_pkg.sv
dispatch_pkg.sv
instr_decoder.sv
reg_file.sv
scoreboard.sv
issue_ctrl.sv
dispatch_reg.sv
decode_stage_top.sv
decode_stage_tb.sv

// ==== Bender.yml ====
package:
  name: decode_stage

sources:
  - isa_pkg.sv
  - dispatch_pkg.sv
  - instr_decoder.sv
  - reg_file.sv
  - scoreboard.sv
  - issue_ctrl.sv
  - dispatch_reg.sv
  - decode_stage_top.sv
  - target: simulation
    files:
      - decode_stage_tb.sv
